//--- run.sh
#!/bin/sh
# Build and run the loopback testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_sl_top -f tb.f -o tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/tb_sim); then
  printf '%s\n' "$sim_out"
  echo "Simulation exited with an error status"
  exit 1
fi
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- sl_data_link.sv
`timescale 1ns/1ps

module sl_data_link #(
  parameter int NumLanes = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Network side
  input  sl_pkg::payload_t    tx_payload_i,
  input  logic                tx_payload_valid_i,
  output logic                tx_payload_ready_o,
  output sl_pkg::payload_t    rx_payload_o,
  output logic                rx_payload_valid_o,
  // Phy side
  output logic [NumLanes-1:0] tx_flit_o,
  output logic                tx_flit_valid_o,
  input  logic                tx_flit_ready_i,
  input  logic [NumLanes-1:0] rx_flit_i,
  input  logic                rx_flit_valid_i
);

  localparam int PayloadSplits = (sl_pkg::PayloadBits + NumLanes - 1) / NumLanes;
  localparam int PadBits       = PayloadSplits * NumLanes;
  localparam int CntBits       = $clog2(PayloadSplits + 1);

  logic [PadBits-1:0] tx_shift_q;
  logic [CntBits-1:0] tx_cnt_q;
  logic               tx_busy_q;
  logic               tx_load;
  logic               tx_flit_xfer;
  logic [PadBits-1:0] rx_shift_q;
  logic [CntBits-1:0] rx_cnt_q;
  logic               rx_done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit serializer
  ////////////////////////////////////////////////////////////////////////////

  assign tx_payload_ready_o = !tx_busy_q;
  assign tx_load            = tx_payload_valid_i && tx_payload_ready_o;
  assign tx_flit_o          = tx_shift_q[NumLanes-1:0];
  assign tx_flit_valid_o    = tx_busy_q;
  assign tx_flit_xfer       = tx_busy_q && tx_flit_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_busy_q <= 1'b0;
      tx_cnt_q  <= '0;
      rx_cnt_q  <= '0;
      rx_done_q <= 1'b0;
    end else begin
      if (tx_load) begin
        tx_busy_q <= 1'b1;
        tx_cnt_q  <= '0;
      end else if (tx_flit_xfer) begin
        tx_cnt_q <= tx_cnt_q + 1'b1;
        if (tx_cnt_q == CntBits'(PayloadSplits - 1)) begin
          tx_busy_q <= 1'b0;
        end
      end
      // Receive counter wraps after the last flit of a payload
      rx_done_q <= 1'b0;
      if (rx_flit_valid_i) begin
        if (rx_cnt_q == CntBits'(PayloadSplits - 1)) begin
          rx_cnt_q  <= '0;
          rx_done_q <= 1'b1;
        end else begin
          rx_cnt_q <= rx_cnt_q + 1'b1;
        end
      end
    end
  end

  // Low bits leave first, the top flit is zero padded
  always_ff @(posedge clk_i) begin
    if (tx_load) begin
      tx_shift_q <= PadBits'(tx_payload_i);
    end else if (tx_flit_xfer) begin
      tx_shift_q <= tx_shift_q >> NumLanes;
    end
    if (rx_flit_valid_i) begin
      rx_shift_q <= (rx_shift_q >> NumLanes) | (PadBits'(rx_flit_i) << (PadBits - NumLanes));
    end
  end

  assign rx_payload_o       = rx_shift_q[sl_pkg::PayloadBits-1:0];
  assign rx_payload_valid_o = rx_done_q;

endmodule

//--- sl_fifo.sv
`timescale 1ns/1ps

module sl_fifo #(
  parameter type elem_t = logic,
  parameter int  Depth  = 8
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  elem_t data_i,
  input  logic  pop_i,
  output elem_t data_o,
  output logic  empty_o
);

  localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntBits = $clog2(Depth + 1);

  elem_t              mem_q [Depth];
  logic [PtrBits-1:0] wr_ptr_q;
  logic [PtrBits-1:0] rd_ptr_q;
  logic [CntBits-1:0] count_q;

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrBits'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrBits'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntBits'(push_i) - CntBits'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- sl_network.sv
`timescale 1ns/1ps

module sl_network #(
  parameter int NumCredits = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // User transmit stream
  input  sl_pkg::msg_t     tx_msg_i,
  input  logic             tx_valid_i,
  output logic             tx_ready_o,
  // User receive stream
  output sl_pkg::msg_t     rx_msg_o,
  output logic             rx_valid_o,
  input  logic             rx_ready_i,
  // Towards the data link
  output sl_pkg::payload_t tx_payload_o,
  output logic             tx_payload_valid_o,
  input  logic             tx_payload_ready_i,
  // From the data link, single cycle pulse
  input  sl_pkg::payload_t rx_payload_i,
  input  logic             rx_payload_valid_i
);

  sl_pkg::payload_t out_q;
  logic             out_valid_q;
  sl_pkg::credit_t  credit_q;
  sl_pkg::credit_t  pending_q;
  sl_pkg::credit_t  rx_credit;
  logic             tx_xfer;
  logic             send_credit;
  logic             payload_done;
  logic             rx_push;
  logic             rx_pop;
  logic             fifo_empty;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit side
  ////////////////////////////////////////////////////////////////////////////

  assign tx_ready_o   = (credit_q != '0) && !out_valid_q;
  assign tx_xfer      = tx_valid_i && tx_ready_o;
  assign payload_done = out_valid_q && tx_payload_ready_i;

  // Credit-only payload when the register is free and no message goes out
  assign send_credit = !out_valid_q && !tx_xfer &&
                       (pending_q >= sl_pkg::credit_t'(NumCredits / 2));

  assign tx_payload_o       = out_q;
  assign tx_payload_valid_o = out_valid_q;

  // Credits returned by the far side arrive with any payload type
  assign rx_credit = rx_payload_valid_i ? rx_payload_i.credit : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      credit_q    <= sl_pkg::credit_t'(NumCredits);
      pending_q   <= '0;
    end else begin
      if (payload_done) begin
        out_valid_q <= 1'b0;
      end else if (tx_xfer || send_credit) begin
        out_valid_q <= 1'b1;
      end
      credit_q <= credit_q - sl_pkg::credit_t'(tx_xfer) + rx_credit;
      // Every outgoing payload drains the whole pending count
      if (tx_xfer || send_credit) begin
        pending_q <= sl_pkg::credit_t'(rx_pop);
      end else begin
        pending_q <= pending_q + sl_pkg::credit_t'(rx_pop);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_xfer) begin
      out_q.msg    <= tx_msg_i;
      out_q.tag    <= sl_pkg::TagData;
      out_q.credit <= pending_q;
    end else if (send_credit) begin
      out_q.msg    <= '0;
      out_q.tag    <= sl_pkg::TagCredit;
      out_q.credit <= pending_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive side
  ////////////////////////////////////////////////////////////////////////////

  assign rx_push    = rx_payload_valid_i && (rx_payload_i.tag == sl_pkg::TagData);
  assign rx_valid_o = !fifo_empty;
  assign rx_pop     = rx_valid_o && rx_ready_i;

  // Sized to the credit count, so it cannot overflow
  sl_fifo #(
    .elem_t ( sl_pkg::msg_t ),
    .Depth  ( NumCredits    )
  ) rx_fifo_i (
    .clk_i   ( clk_i            ),
    .rst_n_i ( rst_n_i          ),
    .push_i  ( rx_push          ),
    .data_i  ( rx_payload_i.msg ),
    .pop_i   ( rx_pop           ),
    .data_o  ( rx_msg_o         ),
    .empty_o ( fifo_empty       )
  );

endmodule

//--- sl_phy.sv
`timescale 1ns/1ps

module sl_phy #(
  parameter int NumLanes = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  sl_pkg::clk_div_t    clk_div_i,
  // Data link side
  input  logic [NumLanes-1:0] tx_flit_i,
  input  logic                tx_flit_valid_i,
  output logic                tx_flit_ready_o,
  output logic [NumLanes-1:0] rx_flit_o,
  output logic                rx_flit_valid_o,
  // Pins
  output logic                sl_clk_o,
  output logic [NumLanes-1:0] sl_lanes_o,
  input  logic                sl_clk_i,
  input  logic [NumLanes-1:0] sl_lanes_i
);

  sl_pkg::clk_div_t          div_cnt_q;
  logic                      tx_busy_q;
  logic                      tx_last;
  logic                      tx_accept;
  logic                      sl_clk_q;
  logic [NumLanes-1:0]       sl_lanes_q;
  logic [1:0]                clk_sync_q;
  logic                      clk_prev_q;
  logic [1:0][NumLanes-1:0]  lanes_sync_q;
  logic                      rx_edge;
  logic [NumLanes-1:0]       rx_flit_q;
  logic                      rx_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit, one forwarded clock period per flit
  ////////////////////////////////////////////////////////////////////////////

  assign tx_last         = tx_busy_q && (div_cnt_q == clk_div_i - 1'b1);
  // Next flit may load on the last cycle, so flits go back to back
  assign tx_flit_ready_o = !tx_busy_q || tx_last;
  assign tx_accept       = tx_flit_valid_i && tx_flit_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_busy_q  <= 1'b0;
      div_cnt_q  <= '0;
      sl_clk_q   <= 1'b0;
      sl_lanes_q <= '0;
    end else begin
      if (tx_accept) begin
        // Lanes change at the start of the low half
        tx_busy_q  <= 1'b1;
        div_cnt_q  <= '0;
        sl_clk_q   <= 1'b0;
        sl_lanes_q <= tx_flit_i;
      end else if (tx_last) begin
        tx_busy_q <= 1'b0;
        div_cnt_q <= '0;
        sl_clk_q  <= 1'b0;
      end else if (tx_busy_q) begin
        div_cnt_q <= div_cnt_q + 1'b1;
        if (div_cnt_q == (clk_div_i >> 1) - 1'b1) begin
          sl_clk_q <= 1'b1;
        end
      end
    end
  end

  assign sl_clk_o   = sl_clk_q;
  assign sl_lanes_o = sl_lanes_q;

  ////////////////////////////////////////////////////////////////////////////
  // Receive, sample on the forwarded clock rising edge
  ////////////////////////////////////////////////////////////////////////////

  assign rx_edge = clk_sync_q[1] && !clk_prev_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_sync_q <= '0;
      clk_prev_q <= 1'b0;
      rx_valid_q <= 1'b0;
    end else begin
      clk_sync_q <= {clk_sync_q[0], sl_clk_i};
      clk_prev_q <= clk_sync_q[1];
      rx_valid_q <= rx_edge;
    end
  end

  // Lanes take the same two stages as the clock, so they line up at the edge
  always_ff @(posedge clk_i) begin
    lanes_sync_q <= {lanes_sync_q[0], sl_lanes_i};
    if (rx_edge) begin
      rx_flit_q <= lanes_sync_q[1];
    end
  end

  assign rx_flit_o       = rx_flit_q;
  assign rx_flit_valid_o = rx_valid_q;

endmodule

//--- sl_pkg.sv
package sl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Message and credit types
  ////////////////////////////////////////////////////////////////////////////

  // Width of one user message
  localparam int MsgBits = 32;

  typedef logic [MsgBits-1:0] msg_t;

  // Credit field width, which caps NumCredits at 15
  localparam int CreditBits = 4;

  typedef logic [CreditBits-1:0] credit_t;

  // Payload header
  // TagData carries a valid message, TagCredit only returns credits
  typedef enum logic [1:0] {
    TagData   = 2'b01,
    TagCredit = 2'b10
  } tag_e;

  ////////////////////////////////////////////////////////////////////////////
  // Network payload
  ////////////////////////////////////////////////////////////////////////////

  // Credit sits in the low bits, so it leaves on the first flits
  typedef struct packed {
    msg_t    msg;
    tag_e    tag;
    credit_t credit;
  } payload_t;

  // 38 bits in total
  localparam int PayloadBits = $bits(payload_t);

  ////////////////////////////////////////////////////////////////////////////
  // Physical layer
  ////////////////////////////////////////////////////////////////////////////

  // Clock divide input, even values from 4 to 30
  localparam int ClkDivBits = 5;

  typedef logic [ClkDivBits-1:0] clk_div_t;

endpackage

//--- sl_top.sv
`timescale 1ns/1ps

module sl_top #(
  parameter int NumLanes   = 8,
  parameter int NumCredits = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  sl_pkg::clk_div_t    clk_div_i,
  // User streams
  input  sl_pkg::msg_t        tx_msg_i,
  input  logic                tx_valid_i,
  output logic                tx_ready_o,
  output sl_pkg::msg_t        rx_msg_o,
  output logic                rx_valid_o,
  input  logic                rx_ready_i,
  // Pins
  output logic                sl_clk_o,
  output logic [NumLanes-1:0] sl_lanes_o,
  input  logic                sl_clk_i,
  input  logic [NumLanes-1:0] sl_lanes_i
);

  sl_pkg::payload_t    tx_payload;
  logic                tx_payload_valid;
  logic                tx_payload_ready;
  sl_pkg::payload_t    rx_payload;
  logic                rx_payload_valid;
  logic [NumLanes-1:0] tx_flit;
  logic                tx_flit_valid;
  logic                tx_flit_ready;
  logic [NumLanes-1:0] rx_flit;
  logic                rx_flit_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Network layer
  ////////////////////////////////////////////////////////////////////////////

  sl_network #(
    .NumCredits ( NumCredits )
  ) sl_network_i (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .tx_msg_i           ( tx_msg_i         ),
    .tx_valid_i         ( tx_valid_i       ),
    .tx_ready_o         ( tx_ready_o       ),
    .rx_msg_o           ( rx_msg_o         ),
    .rx_valid_o         ( rx_valid_o       ),
    .rx_ready_i         ( rx_ready_i       ),
    .tx_payload_o       ( tx_payload       ),
    .tx_payload_valid_o ( tx_payload_valid ),
    .tx_payload_ready_i ( tx_payload_ready ),
    .rx_payload_i       ( rx_payload       ),
    .rx_payload_valid_i ( rx_payload_valid )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data link and physical layers
  ////////////////////////////////////////////////////////////////////////////

  sl_data_link #(
    .NumLanes ( NumLanes )
  ) sl_data_link_i (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .tx_payload_i       ( tx_payload       ),
    .tx_payload_valid_i ( tx_payload_valid ),
    .tx_payload_ready_o ( tx_payload_ready ),
    .rx_payload_o       ( rx_payload       ),
    .rx_payload_valid_o ( rx_payload_valid ),
    .tx_flit_o          ( tx_flit          ),
    .tx_flit_valid_o    ( tx_flit_valid    ),
    .tx_flit_ready_i    ( tx_flit_ready    ),
    .rx_flit_i          ( rx_flit          ),
    .rx_flit_valid_i    ( rx_flit_valid    )
  );

  sl_phy #(
    .NumLanes ( NumLanes )
  ) sl_phy_i (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .clk_div_i       ( clk_div_i     ),
    .tx_flit_i       ( tx_flit       ),
    .tx_flit_valid_i ( tx_flit_valid ),
    .tx_flit_ready_o ( tx_flit_ready ),
    .rx_flit_o       ( rx_flit       ),
    .rx_flit_valid_o ( rx_flit_valid ),
    .sl_clk_o        ( sl_clk_o      ),
    .sl_lanes_o      ( sl_lanes_o    ),
    .sl_clk_i        ( sl_clk_i      ),
    .sl_lanes_i      ( sl_lanes_i    )
  );

endmodule

//--- tb.f
sl_pkg.sv
sl_fifo.sv
sl_network.sv
sl_data_link.sv
sl_phy.sv
sl_top.sv
tb_sl_checker.sv
tb_sl_top.sv

//--- tb_sl_checker.sv
`timescale 1ns/1ps

module tb_sl_checker #(
  parameter int NumLanes   = 8,
  parameter int NumCredits = 8,
  parameter int NameBits   = 96
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  sl_pkg::clk_div_t    clk_div_i,
  // DUT user streams
  input  sl_pkg::msg_t        tx_msg_i,
  input  logic                tx_valid_i,
  input  logic                tx_ready_i,
  input  sl_pkg::msg_t        rx_msg_i,
  input  logic                rx_valid_i,
  input  logic                rx_ready_i,
  // DUT transmit pins
  input  logic                fwd_clk_i,
  input  logic [NumLanes-1:0] lanes_i,
  // Current test
  input  logic [NameBits-1:0] test_name_i,
  input  int                  test_msgs_i,
  input  int                  test_hold_i,
  input  logic                test_done_i,
  // Totals
  output int                  outstanding_o,
  output int                  error_count_o,
  output int                  checked_count_o,
  output int                  failed_tests_o
);

  sl_pkg::msg_t expect_q [$];
  sl_pkg::msg_t expected;
  logic         after_reset = 1'b0;
  int           recv_cnt = 0;
  int           blocked_cnt = 0;
  int           blocked_exp = 0;
  int           high_cnt = 0;
  int           test_errors = 0;
  int           error_count = 0;
  int           checked_count = 0;
  int           failed_tests = 0;
  int           outstanding = 0;

  assign outstanding_o   = outstanding;
  assign error_count_o   = error_count;
  assign checked_count_o = checked_count;
  assign failed_tests_o  = failed_tests;

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", test_name_i, what, exp, act);
      test_errors++;
      error_count++;
    end
  endtask

  always @(posedge clk_i) begin
    // Idle outputs in reset and on the first cycle after it
    if (!rst_n_i || after_reset) begin
      check_value("rx_valid_o", 32'd0, 32'(rx_valid_i));
      check_value("sl_clk_o", 32'd0, 32'(fwd_clk_i));
      check_value("sl_lanes_o", 32'd0, 32'(lanes_i));
      if (after_reset) begin
        check_value("tx_ready_o after reset", 32'd1, 32'(tx_ready_i));
      end
      after_reset = !rst_n_i;
    end

    if (rst_n_i) begin
      if (tx_valid_i && tx_ready_i) begin
        expect_q.push_back(tx_msg_i);
        if (!rx_ready_i) begin
          blocked_cnt++;
        end
      end
      if (rx_valid_i && rx_ready_i) begin
        recv_cnt++;
        if (expect_q.size() == 0) begin
          $display("Message received on rx_msg_o in %s with none outstanding", test_name_i);
          test_errors++;
          error_count++;
        end else begin
          expected = expect_q.pop_front();
          check_value("rx_msg_o", expected, rx_msg_i);
          checked_count++;
        end
      end
      // Forwarded clock is high for the second half of each flit
      if (fwd_clk_i) begin
        high_cnt++;
      end else if (high_cnt != 0) begin
        check_value("sl_clk_o high cycles", 32'(clk_div_i) / 32'd2, 32'(high_cnt));
        high_cnt = 0;
      end
    end
    outstanding = expect_q.size();

    ////////////////////////////////////////////////////////////////////////////
    // End of test
    ////////////////////////////////////////////////////////////////////////////

    if (test_done_i) begin
      // A stalled receiver lets exactly the credit count through
      blocked_exp = (test_hold_i == 0) ? 0 :
                    ((test_msgs_i < NumCredits) ? test_msgs_i : NumCredits);
      check_value("messages received", 32'(test_msgs_i), 32'(recv_cnt));
      check_value("accepted while rx_ready_i low", 32'(blocked_exp), 32'(blocked_cnt));
      $display("%s: %0d received, %0d accepted while blocked, %0d errors",
               test_name_i, recv_cnt, blocked_cnt, test_errors);
      if (test_errors != 0) begin
        failed_tests++;
      end
      recv_cnt    = 0;
      blocked_cnt = 0;
      test_errors = 0;
    end
  end

endmodule

//--- tb_sl_top.sv
`timescale 1ns/1ps

module tb_sl_top;

  localparam int NumLanes    = 8;
  localparam int NumCredits  = 8;
  localparam int NameBits    = 96;
  localparam int NumTests    = 5;
  localparam int FlitsPerMsg = (sl_pkg::PayloadBits + NumLanes - 1) / NumLanes;

  // Names are padded to twelve characters
  typedef struct packed {
    logic [NameBits-1:0] name;
    sl_pkg::clk_div_t    clk_div;
    int                  msgs;
    int                  hold;
    sl_pkg::msg_t        base;
  } test_row_t;

  localparam test_row_t Rows [NumTests] = '{
    '{"reset       ", 5'd4,  0,  0,   32'h0000_0000},
    '{"single      ", 5'd4,  1,  0,   32'hdead_beef},
    '{"burst       ", 5'd4,  20, 0,   32'h1234_5678},
    '{"backpressure", 5'd4,  12, 400, 32'ha5a5_0000},
    '{"slow_clock  ", 5'd10, 16, 0,   32'h0f0f_f0f0}
  };

  logic                clk_i;
  logic                rst_n_i;
  sl_pkg::clk_div_t    clk_div_i;
  sl_pkg::msg_t        tx_msg_i;
  logic                tx_valid_i;
  logic                tx_ready_o;
  sl_pkg::msg_t        rx_msg_o;
  logic                rx_valid_o;
  logic                rx_ready_i;
  logic                sl_clk_o;
  logic [NumLanes-1:0] sl_lanes_o;
  logic                sl_clk_i;
  logic [NumLanes-1:0] sl_lanes_i;
  logic [NameBits-1:0] test_name;
  int                  test_msgs;
  int                  test_hold;
  logic                test_done;
  int                  outstanding;
  int                  error_count;
  int                  checked_count;
  int                  failed_tests;

  always #20 clk_i = ~clk_i;

  // Pins loop back, so the link returns credits to itself
  assign sl_clk_i   = sl_clk_o;
  assign sl_lanes_i = sl_lanes_o;

  sl_top #(
    .NumLanes   ( NumLanes   ),
    .NumCredits ( NumCredits )
  ) sl_top_i (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .clk_div_i  ( clk_div_i  ),
    .tx_msg_i   ( tx_msg_i   ),
    .tx_valid_i ( tx_valid_i ),
    .tx_ready_o ( tx_ready_o ),
    .rx_msg_o   ( rx_msg_o   ),
    .rx_valid_o ( rx_valid_o ),
    .rx_ready_i ( rx_ready_i ),
    .sl_clk_o   ( sl_clk_o   ),
    .sl_lanes_o ( sl_lanes_o ),
    .sl_clk_i   ( sl_clk_i   ),
    .sl_lanes_i ( sl_lanes_i )
  );

  tb_sl_checker #(
    .NumLanes   ( NumLanes   ),
    .NumCredits ( NumCredits ),
    .NameBits   ( NameBits   )
  ) checker_i (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .clk_div_i       ( clk_div_i     ),
    .tx_msg_i        ( tx_msg_i      ),
    .tx_valid_i      ( tx_valid_i    ),
    .tx_ready_i      ( tx_ready_o    ),
    .rx_msg_i        ( rx_msg_o      ),
    .rx_valid_i      ( rx_valid_o    ),
    .rx_ready_i      ( rx_ready_i    ),
    .fwd_clk_i       ( sl_clk_o      ),
    .lanes_i         ( sl_lanes_o    ),
    .test_name_i     ( test_name     ),
    .test_msgs_i     ( test_msgs     ),
    .test_hold_i     ( test_hold     ),
    .test_done_i     ( test_done     ),
    .outstanding_o   ( outstanding   ),
    .error_count_o   ( error_count   ),
    .checked_count_o ( checked_count ),
    .failed_tests_o  ( failed_tests  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  // Reset edge lands on the first falling clock edge
  task automatic apply_reset();
    @(negedge clk_i);
    rst_n_i = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
  endtask

  // tx_ready_o comes from registers, so its value here decides the next edge
  task automatic send_message(input sl_pkg::msg_t msg);
    logic taken;
    tx_msg_i   = msg;
    tx_valid_i = 1'b1;
    taken      = 1'b0;
    while (!taken) begin
      taken = tx_ready_o;
      @(negedge clk_i);
    end
  endtask

  task automatic send_burst(input test_row_t row);
    for (int n = 0; n < row.msgs; n++) begin
      send_message(row.base ^ $urandom());
    end
    tx_valid_i = 1'b0;
  endtask

  task automatic release_rx_ready(input int hold);
    if (hold > 0) begin
      repeat (hold) @(negedge clk_i);
      rx_ready_i = 1'b1;
    end
  endtask

  // Quiet longer than any gap between flits means the phy is idle
  task automatic wait_link_idle(input int clk_div);
    int quiet;
    quiet = 0;
    while (quiet < 2 * clk_div + 8) begin
      @(negedge clk_i);
      if (sl_clk_o) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  task automatic run_test(input test_row_t row, input bit with_reset);
    test_name = row.name;
    test_msgs = row.msgs;
    test_hold = row.hold;
    clk_div_i = row.clk_div;
    if (with_reset) begin
      apply_reset();
    end
    rx_ready_i = (row.hold == 0);
    fork
      send_burst(row);
      release_rx_ready(row.hold);
    join
    while (outstanding != 0) begin
      @(negedge clk_i);
    end
    // Divider only changes once the transmit side has drained
    wait_link_idle(int'(row.clk_div));
    test_done = 1'b1;
    @(negedge clk_i);
    test_done = 1'b0;
  endtask

  function automatic int watchdog_cycles();
    int total;
    total = 2000;
    for (int i = 0; i < NumTests; i++) begin
      total += Rows[i].msgs * FlitsPerMsg * int'(Rows[i].clk_div) * 3;
    end
    return total;
  endfunction

  initial begin
    void'($urandom(42));
    clk_i      = 1'b0;
    rst_n_i    = 1'b1;
    clk_div_i  = Rows[0].clk_div;
    tx_msg_i   = '0;
    tx_valid_i = 1'b0;
    rx_ready_i = 1'b1;
    test_done  = 1'b0;
    for (int i = 0; i < NumTests; i++) begin
      run_test(Rows[i], i == 0);
    end
    @(negedge clk_i);
    $display("Summary: %0d tests, %0d with errors, %0d messages checked, %0d errors",
             NumTests, failed_tests, checked_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    int limit;
    limit = watchdog_cycles();
    repeat (limit) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles before all tests finished", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule
